// ==== src/mem_merge_pkg.sv ====
/*
 * Memory bank merge package
 * Request opcode encoding and the bank numbering shared by the
 * router, the order FIFO, the banks and the response merger.
 */
package mem_merge_pkg;

    // Single-beat request opcode
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // Two banks side by side, one address window each
    localparam int NUM_BANKS = 2;

    // Width of a bank index
    localparam int BANK_IDX_WIDTH = $clog2(NUM_BANKS);

    // Names one bank, as recorded in the order FIFO
    typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;

endpackage : mem_merge_pkg

// ==== src/bank_order_fifo.sv ====
/*
 * Bank order FIFO
 * Records the bank index of every accepted request so that responses
 * can be returned in request order. Circular buffer with a fill count.
 */
module bank_order_fifo #(
    parameter int ORDER_DEPTH_LOG2 = 3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  mem_merge_pkg::bank_idx_t push_idx,
    output logic                     full,
    input  logic                     pop,
    output mem_merge_pkg::bank_idx_t head_idx,
    output logic                     head_valid
);
    import mem_merge_pkg::*;

    localparam int DEPTH = 1 << ORDER_DEPTH_LOG2;

    bank_idx_t                   entries [DEPTH];
    logic [ORDER_DEPTH_LOG2-1:0] wr_ptr;
    logic [ORDER_DEPTH_LOG2-1:0] rd_ptr;
    logic [ORDER_DEPTH_LOG2:0]   count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_idx;
        end
    end

    assign full       = (count == (ORDER_DEPTH_LOG2 + 1)'(DEPTH));
    assign head_valid = (count != '0);
    assign head_idx   = entries[rd_ptr];

    // Router and merger must respect the FIFO state
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_valid);

endmodule : bank_order_fifo

// ==== src/bank_req_router.sv ====
/*
 * Bank request router
 * Decodes the owning bank from the address window bit, strips that bit,
 * and loads a registered request slot for the addressed bank. A new
 * request is taken only when every slot can take one and the order
 * FIFO has room.
 */
module bank_req_router #(
    parameter int ADDR_WIDTH  = 12,
    parameter int DATA_WIDTH  = 32,
    parameter int WINDOW_LOG2 = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  mem_merge_pkg::mem_op_e   req_op,
    input  logic [ADDR_WIDTH-1:0]    req_addr,
    input  logic [DATA_WIDTH-1:0]    req_wdata,
    output logic                     b0_req_valid,
    input  logic                     b0_req_ready,
    output mem_merge_pkg::mem_op_e   b0_req_op,
    output logic [ADDR_WIDTH-2:0]    b0_req_addr,
    output logic [DATA_WIDTH-1:0]    b0_req_wdata,
    output logic                     b1_req_valid,
    input  logic                     b1_req_ready,
    output mem_merge_pkg::mem_op_e   b1_req_op,
    output logic [ADDR_WIDTH-2:0]    b1_req_addr,
    output logic [DATA_WIDTH-1:0]    b1_req_wdata,
    input  logic                     order_full,
    output logic                     order_push,
    output mem_merge_pkg::bank_idx_t order_push_idx
);
    import mem_merge_pkg::*;

    localparam int BANK_ADDR_WIDTH = ADDR_WIDTH - 1;

    // Bank owning the window that holds this address
    function automatic bank_idx_t addr_to_bank(input logic [ADDR_WIDTH-1:0] addr);
        return bank_idx_t'(addr[WINDOW_LOG2]);
    endfunction

    // Address within the bank, window bit removed
    function automatic logic [BANK_ADDR_WIDTH-1:0] addr_to_bank_addr(
        input logic [ADDR_WIDTH-1:0] addr
    );
        return {addr[ADDR_WIDTH-1:WINDOW_LOG2+1], addr[WINDOW_LOG2-1:0]};
    endfunction

    bank_idx_t                  req_bank;
    logic                       accept;
    logic [NUM_BANKS-1:0]       slot_valid;
    logic [NUM_BANKS-1:0]       slot_ready;
    logic [NUM_BANKS-1:0]       slot_free;
    mem_op_e                    slot_op    [NUM_BANKS];
    logic [BANK_ADDR_WIDTH-1:0] slot_addr  [NUM_BANKS];
    logic [DATA_WIDTH-1:0]      slot_wdata [NUM_BANKS];

    assign req_bank   = addr_to_bank(req_addr);
    assign slot_ready = {b1_req_ready, b0_req_ready};

    // A slot can take a request if empty or draining this cycle
    assign slot_free = ~slot_valid | slot_ready;
    assign req_ready = (&slot_free) && !order_full;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (accept && req_bank == bank_idx_t'(b)) begin
                    slot_valid[b] <= 1'b1;
                end else if (slot_ready[b]) begin
                    slot_valid[b] <= 1'b0;
                end
            end
        end
    end

    // Only the addressed slot loads
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (accept && req_bank == bank_idx_t'(b)) begin
                slot_op[b]    <= req_op;
                slot_addr[b]  <= addr_to_bank_addr(req_addr);
                slot_wdata[b] <= req_wdata;
            end
        end
    end

    assign b0_req_valid = slot_valid[0];
    assign b0_req_op    = slot_op[0];
    assign b0_req_addr  = slot_addr[0];
    assign b0_req_wdata = slot_wdata[0];
    assign b1_req_valid = slot_valid[1];
    assign b1_req_op    = slot_op[1];
    assign b1_req_addr  = slot_addr[1];
    assign b1_req_wdata = slot_wdata[1];

    // Every accepted request records its bank for the merger
    assign order_push     = accept;
    assign order_push_idx = req_bank;

endmodule : bank_req_router

// ==== src/bank_mem.sv ====
/*
 * Behavioural memory bank
 * Word storage with a fixed-latency response pipeline. The pipeline
 * freezes while the output response is held off, and new requests
 * are refused for as long as it is frozen.
 */
module bank_mem #(
    parameter int ADDR_WIDTH  = 11,
    parameter int DATA_WIDTH  = 32,
    parameter int RSP_LATENCY = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  mem_merge_pkg::mem_op_e req_op,
    input  logic [ADDR_WIDTH-1:0]  req_addr,
    input  logic [DATA_WIDTH-1:0]  req_wdata,
    output logic                   rsp_valid,
    output mem_merge_pkg::mem_op_e rsp_op,
    output logic [DATA_WIDTH-1:0]  rsp_rdata,
    input  logic                   rsp_ready
);
    import mem_merge_pkg::*;

    localparam int WORDS = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] storage    [WORDS];
    logic                  pipe_valid [RSP_LATENCY];
    mem_op_e               pipe_op    [RSP_LATENCY];
    logic [DATA_WIDTH-1:0] pipe_data  [RSP_LATENCY];
    logic                  stall;
    logic                  accept;
    logic [DATA_WIDTH-1:0] rd_word;

    // Last stage holds a response the merger has not taken
    assign stall     = pipe_valid[RSP_LATENCY-1] && !rsp_ready;
    assign req_ready = !stall;
    assign accept    = req_valid && req_ready;
    assign rd_word   = storage[req_addr];

    always_ff @(posedge clk) begin
        if (accept && req_op == op_write) begin
            storage[req_addr] <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RSP_LATENCY; i++) begin
                pipe_valid[i] <= 1'b0;
            end
        end else if (!stall) begin
            pipe_valid[0] <= accept;
            for (int i = 1; i < RSP_LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    // Write responses carry back the data just stored
    always_ff @(posedge clk) begin
        if (!stall) begin
            pipe_op[0]   <= req_op;
            pipe_data[0] <= (req_op == op_write) ? req_wdata : rd_word;
            for (int i = 1; i < RSP_LATENCY; i++) begin
                pipe_op[i]   <= pipe_op[i-1];
                pipe_data[i] <= pipe_data[i-1];
            end
        end
    end

    assign rsp_valid = pipe_valid[RSP_LATENCY-1];
    assign rsp_op    = pipe_op[RSP_LATENCY-1];
    assign rsp_rdata = pipe_data[RSP_LATENCY-1];

    // A held response must not change until the merger takes it
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_op) && $stable(rsp_rdata))
    );

endmodule : bank_mem

// ==== src/rsp_merge.sv ====
/*
 * Response merger
 * Returns the response of the bank named at the order FIFO head and
 * steers the ready back to that bank only. The other bank waits.
 */
module rsp_merge #(
    parameter int DATA_WIDTH = 32
) (
    input  mem_merge_pkg::bank_idx_t head_idx,
    input  logic                     head_valid,
    input  logic                     b0_rsp_valid,
    input  mem_merge_pkg::mem_op_e   b0_rsp_op,
    input  logic [DATA_WIDTH-1:0]    b0_rsp_rdata,
    output logic                     b0_rsp_ready,
    input  logic                     b1_rsp_valid,
    input  mem_merge_pkg::mem_op_e   b1_rsp_op,
    input  logic [DATA_WIDTH-1:0]    b1_rsp_rdata,
    output logic                     b1_rsp_ready,
    output logic                     rsp_valid,
    output mem_merge_pkg::mem_op_e   rsp_op,
    output logic [DATA_WIDTH-1:0]    rsp_rdata,
    input  logic                     rsp_ready,
    output logic                     order_pop
);
    import mem_merge_pkg::*;

    logic                  bank_valid [NUM_BANKS];
    mem_op_e               bank_op    [NUM_BANKS];
    logic [DATA_WIDTH-1:0] bank_rdata [NUM_BANKS];
    logic [NUM_BANKS-1:0]  bank_ready;

    assign bank_valid[0] = b0_rsp_valid;
    assign bank_op[0]    = b0_rsp_op;
    assign bank_rdata[0] = b0_rsp_rdata;
    assign bank_valid[1] = b1_rsp_valid;
    assign bank_op[1]    = b1_rsp_op;
    assign bank_rdata[1] = b1_rsp_rdata;

    // Only the bank expected next may present a response
    assign rsp_valid = head_valid && bank_valid[head_idx];
    assign rsp_op    = bank_op[head_idx];
    assign rsp_rdata = bank_rdata[head_idx];

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_ready[b] = rsp_ready && head_valid && (head_idx == bank_idx_t'(b));
        end
    end

    assign b0_rsp_ready = bank_ready[0];
    assign b1_rsp_ready = bank_ready[1];

    // One FIFO entry retires per returned response
    assign order_pop = rsp_valid && rsp_ready;

endmodule : rsp_merge

// ==== src/mem_merge_top.sv ====
/*
 * Two-bank memory merge
 * Presents two banks as one flat address space, interleaved by
 * address window, with responses returned in request order.
 */
module mem_merge_top #(
    parameter int ADDR_WIDTH       = 12,
    parameter int DATA_WIDTH       = 32,
    parameter int WINDOW_LOG2      = 4,
    parameter int ORDER_DEPTH_LOG2 = 3,
    parameter int LATENCY_BANK0    = 2,
    parameter int LATENCY_BANK1    = 5
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  mem_merge_pkg::mem_op_e req_op,
    input  logic [ADDR_WIDTH-1:0]  req_addr,
    input  logic [DATA_WIDTH-1:0]  req_wdata,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output mem_merge_pkg::mem_op_e rsp_op,
    output logic [DATA_WIDTH-1:0]  rsp_rdata
);
    import mem_merge_pkg::*;

    localparam int BANK_ADDR_WIDTH = ADDR_WIDTH - 1;

    logic                       b0_req_valid;
    logic                       b0_req_ready;
    mem_op_e                    b0_req_op;
    logic [BANK_ADDR_WIDTH-1:0] b0_req_addr;
    logic [DATA_WIDTH-1:0]      b0_req_wdata;
    logic                       b0_rsp_valid;
    logic                       b0_rsp_ready;
    mem_op_e                    b0_rsp_op;
    logic [DATA_WIDTH-1:0]      b0_rsp_rdata;

    logic                       b1_req_valid;
    logic                       b1_req_ready;
    mem_op_e                    b1_req_op;
    logic [BANK_ADDR_WIDTH-1:0] b1_req_addr;
    logic [DATA_WIDTH-1:0]      b1_req_wdata;
    logic                       b1_rsp_valid;
    logic                       b1_rsp_ready;
    mem_op_e                    b1_rsp_op;
    logic [DATA_WIDTH-1:0]      b1_rsp_rdata;

    logic                       order_full;
    logic                       order_push;
    bank_idx_t                  order_push_idx;
    logic                       order_pop;
    bank_idx_t                  head_idx;
    logic                       head_valid;

    bank_req_router #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .WINDOW_LOG2(WINDOW_LOG2)
    ) router_inst (
        .clk,
        .rst_n,
        .req_valid,
        .req_ready,
        .req_op,
        .req_addr,
        .req_wdata,
        .b0_req_valid,
        .b0_req_ready,
        .b0_req_op,
        .b0_req_addr,
        .b0_req_wdata,
        .b1_req_valid,
        .b1_req_ready,
        .b1_req_op,
        .b1_req_addr,
        .b1_req_wdata,
        .order_full,
        .order_push,
        .order_push_idx
    );

    bank_order_fifo #(
        .ORDER_DEPTH_LOG2(ORDER_DEPTH_LOG2)
    ) order_fifo_inst (
        .clk,
        .rst_n,
        .push      (order_push),
        .push_idx  (order_push_idx),
        .full      (order_full),
        .pop       (order_pop),
        .head_idx,
        .head_valid
    );

    bank_mem #(
        .ADDR_WIDTH (BANK_ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .RSP_LATENCY(LATENCY_BANK0)
    ) bank0_inst (
        .clk,
        .rst_n,
        .req_valid(b0_req_valid),
        .req_ready(b0_req_ready),
        .req_op   (b0_req_op),
        .req_addr (b0_req_addr),
        .req_wdata(b0_req_wdata),
        .rsp_valid(b0_rsp_valid),
        .rsp_op   (b0_rsp_op),
        .rsp_rdata(b0_rsp_rdata),
        .rsp_ready(b0_rsp_ready)
    );

    bank_mem #(
        .ADDR_WIDTH (BANK_ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .RSP_LATENCY(LATENCY_BANK1)
    ) bank1_inst (
        .clk,
        .rst_n,
        .req_valid(b1_req_valid),
        .req_ready(b1_req_ready),
        .req_op   (b1_req_op),
        .req_addr (b1_req_addr),
        .req_wdata(b1_req_wdata),
        .rsp_valid(b1_rsp_valid),
        .rsp_op   (b1_rsp_op),
        .rsp_rdata(b1_rsp_rdata),
        .rsp_ready(b1_rsp_ready)
    );

    rsp_merge #(
        .DATA_WIDTH(DATA_WIDTH)
    ) merge_inst (
        .head_idx,
        .head_valid,
        .b0_rsp_valid,
        .b0_rsp_op,
        .b0_rsp_rdata,
        .b0_rsp_ready,
        .b1_rsp_valid,
        .b1_rsp_op,
        .b1_rsp_rdata,
        .b1_rsp_ready,
        .rsp_valid,
        .rsp_op,
        .rsp_rdata,
        .rsp_ready,
        .order_pop
    );

endmodule : mem_merge_top

// ==== dv/mem_merge_tb.sv ====
/*
 * Testbench for the two-bank memory merge
 * Drives single-beat reads and writes into the flat address space,
 * keeps a reference memory and an expected response queue, and checks
 * every returned response with assertions.
 */
module mem_merge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_merge_pkg::*;

    localparam int ADDR_WIDTH       = 12;
    localparam int DATA_WIDTH       = 32;
    localparam int WINDOW_LOG2      = 4;
    localparam int ORDER_DEPTH_LOG2 = 3;
    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 5;
    localparam int RESET_CYCLES     = 4;
    localparam logic [31:0] SEED    = 32'd69;

    // Request counts per phase
    localparam int NUM_INIT     = 16;
    localparam int NUM_DIRECTED = 6;
    localparam int NUM_RAND     = 200;
    localparam int TOTAL_REQS   = NUM_INIT + NUM_DIRECTED + NUM_RAND;
    localparam int CNT_W        = $clog2(TOTAL_REQS + 1);
    localparam int EXP_DEPTH    = 1 << CNT_W;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_REQS * 20;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    mem_op_e               req_op;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic                  rsp_valid;
    logic                  rsp_ready;
    mem_op_e               rsp_op;
    logic [DATA_WIDTH-1:0] rsp_rdata;
    logic                  random_gaps;

    // Reference model state
    logic [DATA_WIDTH-1:0] ref_mem  [1 << ADDR_WIDTH];
    mem_op_e               exp_op   [EXP_DEPTH];
    logic [DATA_WIDTH-1:0] exp_data [EXP_DEPTH];
    logic [CNT_W-1:0]      acc_count;
    logic [CNT_W-1:0]      rsp_count;

    mem_merge_top #(
        .ADDR_WIDTH      (ADDR_WIDTH),
        .DATA_WIDTH      (DATA_WIDTH),
        .WINDOW_LOG2     (WINDOW_LOG2),
        .ORDER_DEPTH_LOG2(ORDER_DEPTH_LOG2),
        .LATENCY_BANK0   (2),
        .LATENCY_BANK1   (5)
    ) mem_merge_top_inst (
        .clk,
        .rst_n,
        .req_valid,
        .req_ready,
        .req_op,
        .req_addr,
        .req_wdata,
        .rsp_valid,
        .rsp_ready,
        .rsp_op,
        .rsp_rdata
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // A few words per bank, bank chosen by bit 2, upper window by bit 3
    function automatic logic [ADDR_WIDTH-1:0] pick_addr(input logic [31:0] r);
        logic [ADDR_WIDTH-1:0] a;
        a = '0;
        a[1:0] = r[1:0];
        a[WINDOW_LOG2] = r[2];
        a[WINDOW_LOG2+1] = r[3];
        return a;
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    // Called at edge plus drive delay, returns the same way after the handshake
    task automatic send_req(input mem_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = data;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        req_valid = 1'b0;
    endtask

    task automatic drain_responses();
        forever begin
            if (rsp_count == acc_count) begin
                break;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected response of every accepted request, in arrival order
    always @(posedge clk) begin
        if (!rst_n) begin
            acc_count <= '0;
            rsp_count <= '0;
        end else begin
            if (req_valid && req_ready) begin
                exp_op[acc_count]   <= req_op;
                exp_data[acc_count] <= (req_op == op_write) ? req_wdata : ref_mem[req_addr];
                if (req_op == op_write) begin
                    ref_mem[req_addr] <= req_wdata;
                end
                acc_count <= acc_count + 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                rsp_count <= rsp_count + 1'b1;
            end
        end
    end

    a_rsp_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && rsp_ready) |->
            (rsp_op == exp_op[rsp_count] && rsp_rdata == exp_data[rsp_count])
    ) else stop_with_error($sformatf(
        "FAIL %0t: response %0d got op %0d data %h, expected op %0d data %h",
        $time, $sampled(rsp_count), $sampled(rsp_op), $sampled(rsp_rdata),
        exp_op[$sampled(rsp_count)], exp_data[$sampled(rsp_count)]));

    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_op) && $stable(rsp_rdata))
    ) else stop_with_error($sformatf(
        "FAIL %0t: held response changed before transfer", $time));

    // No response without an outstanding request
    a_no_extra_rsp: assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid |-> (rsp_count < acc_count)
    ) else stop_with_error($sformatf(
        "FAIL %0t: response %0d with only %0d requests accepted",
        $time, $sampled(rsp_count), $sampled(acc_count)));

    initial begin : drive_rsp_ready
        logic [31:0] gap_state;
        gap_state = xorshift32(SEED);
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            gap_state = xorshift32(gap_state);
            rsp_ready = !random_gaps || (gap_state[1:0] != 2'b00);
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error($sformatf("Watchdog timeout: run did not finish within %0d cycles",
                                  WATCHDOG_CYCLES));
    end

    initial begin : run_tests
        logic [31:0] stim_state;
        logic [31:0] data;
        int          wait_cycles;
        stim_state  = SEED;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_op      = op_read;
        req_addr    = '0;
        req_wdata   = '0;
        random_gaps = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Idle outputs and request side opening after reset
        @(posedge clk);
        assert (!rsp_valid) else stop_with_error("rsp_valid was high right after reset");
        wait_cycles = 0;
        while (!req_ready && wait_cycles < 4) begin
            @(posedge clk);
            wait_cycles++;
        end
        assert (req_ready) else stop_with_error("req_ready did not rise after reset");
        #DRIVE_DELAY;

        // Give every used word a known value
        for (int i = 0; i < NUM_INIT; i++) begin
            stim_state = xorshift32(stim_state);
            send_req(op_write, pick_addr(32'(i)), stim_state);
        end
        drain_responses();

        // Slow bank 1 read directly followed by a fast bank 0 read
        send_req(op_read, pick_addr(32'd4), '0);
        send_req(op_read, pick_addr(32'd0), '0);

        // Same word offset in both windows
        send_req(op_write, pick_addr(32'd1), 32'h1111_0001);
        send_req(op_write, pick_addr(32'd5), 32'h2222_0005);
        send_req(op_read, pick_addr(32'd1), '0);
        send_req(op_read, pick_addr(32'd5), '0);
        drain_responses();

        random_gaps = 1'b1;
        for (int i = 0; i < NUM_RAND; i++) begin
            stim_state = xorshift32(stim_state);
            data = xorshift32(stim_state ^ 32'h9e37_79b9);
            if (stim_state[7:6] == 2'b00) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            send_req(mem_op_e'(stim_state[4]), pick_addr(stim_state), data);
        end
        drain_responses();
        repeat (2) @(posedge clk);

        if (rsp_count == acc_count && acc_count == CNT_W'(TOTAL_REQS)) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_with_error($sformatf("Response count %0d does not match %0d accepted requests",
                                      rsp_count, acc_count));
        end
    end

endmodule : mem_merge_tb

// ==== mem_merge_top.f ====
src/mem_merge_pkg.sv
src/bank_order_fifo.sv
src/bank_req_router.sv
src/bank_mem.sv
src/rsp_merge.sv
src/mem_merge_top.sv
dv/mem_merge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory merge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_merge_tb -f mem_merge_top.f -o mem_merge_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/mem_merge_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "sim passed"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
